//--- include/io_clk_macros.svh
`ifndef IO_CLK_MACROS_SVH
`define IO_CLK_MACROS_SVH

// divided tap count, fixed taps first
`define IO_CLK_NUM_DIV      8
`define IO_CLK_NUM_FIXED    4
`define IO_CLK_NUM_PROG     4

// counter wide enough for divide by 32
`define IO_CLK_CNT_W        5

// register map
`define IO_CLK_ADDR_SEL     1'b0   // tap select
`define IO_CLK_ADDR_RATIO   1'b1   // four ratio codes

// fixed taps, counter bit = log2(ratio) - 1
`define IO_CLK_TAP0_BIT     0      // div 2
`define IO_CLK_TAP1_BIT     1      // div 4
`define IO_CLK_TAP2_BIT     2      // div 8
`define IO_CLK_TAP3_BIT     3      // div 16

`endif

//--- verilog/io_clk_pkg.sv
`include "io_clk_macros.svh"

package io_clk_pkg;

    // tap index, bit 2 set means programmable re-timed tap
    typedef logic [2:0] io_clk_sel_t;

    // ratio code c divides by 2**(c+1)
    typedef logic [1:0] clk_ratio_t;

    // code i in bits 2i+1:2i, belongs to tap 4+i
    typedef logic [`IO_CLK_NUM_PROG*2-1:0] clk_ratio_vec_t;

    typedef logic [`IO_CLK_CNT_W-1:0] div_cnt_t;

    // one level per divided tap
    typedef logic [`IO_CLK_NUM_DIV-1:0] div_taps_t;

    // config bus
    typedef logic       cfg_addr_t;
    typedef logic [7:0] cfg_data_t;

endpackage

//--- verilog/io_clk_cfg_regs.sv
`timescale 1ns/1ps
`include "io_clk_macros.svh"

module io_clk_cfg_regs (
    input  logic                       divided_clk_src,
    input  logic                       rst_n,
    input  logic                       cfg_wr,
    input  io_clk_pkg::cfg_addr_t      cfg_addr,
    input  io_clk_pkg::cfg_data_t      cfg_wdata,
    input  io_clk_pkg::cfg_addr_t      cfg_rd_addr,
    output io_clk_pkg::cfg_data_t      cfg_rdata,
    output io_clk_pkg::io_clk_sel_t    clock_select,
    output logic                       clock_update,
    output io_clk_pkg::clk_ratio_vec_t divided_clk_sels
);

    import io_clk_pkg::*;

    logic sel_wr;
    logic ratio_wr;

    assign sel_wr   = cfg_wr && (cfg_addr == `IO_CLK_ADDR_SEL);
    assign ratio_wr = cfg_wr && (cfg_addr == `IO_CLK_ADDR_RATIO);

    // select register and update strobe
    always_ff @(posedge divided_clk_src) begin
        if (!rst_n) begin
            clock_select <= '0;
            clock_update <= 1'b0;
        end else begin
            clock_update <= sel_wr;   // high for one cycle after the write
            if (sel_wr) begin
                clock_select <= cfg_wdata[$bits(io_clk_sel_t)-1:0];
            end
        end
    end

    always_ff @(posedge divided_clk_src) begin
        if (!rst_n) begin
            divided_clk_sels <= '0;
        end else if (ratio_wr) begin
            divided_clk_sels <= cfg_wdata[$bits(clk_ratio_vec_t)-1:0];
        end
    end

    // readback
    always_comb begin
        if (cfg_rd_addr == `IO_CLK_ADDR_RATIO) begin
            cfg_rdata = cfg_data_t'(divided_clk_sels);
        end else begin
            cfg_rdata = cfg_data_t'(clock_select);   // zero-extended
        end
    end

endmodule

//--- verilog/io_clk_div_bank.sv
`timescale 1ns/1ps
`include "io_clk_macros.svh"

module io_clk_div_bank (
    input  logic                       divided_clk_src,
    input  logic                       rst_n,
    input  logic                       clk_en,
    input  io_clk_pkg::clk_ratio_vec_t divided_clk_sels,
    output io_clk_pkg::div_taps_t      divided_clks
);

    import io_clk_pkg::*;

    div_cnt_t                    div_cnt;
    logic [`IO_CLK_NUM_FIXED-1:0] fixed_bits;
    logic [`IO_CLK_NUM_PROG-1:0]  prog_bits;

    // free-running, holds while clk_en is low
    always_ff @(posedge divided_clk_src) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (clk_en) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign fixed_bits = {div_cnt[`IO_CLK_TAP3_BIT],
                         div_cnt[`IO_CLK_TAP2_BIT],
                         div_cnt[`IO_CLK_TAP1_BIT],
                         div_cnt[`IO_CLK_TAP0_BIT]};

    // code c picks counter bit c
    always_comb begin
        for (int i = 0; i < `IO_CLK_NUM_PROG; i++) begin
            prog_bits[i] = div_cnt[divided_clk_sels[i*$bits(clk_ratio_t) +: $bits(clk_ratio_t)]];
        end
    end

    // registered taps, a ratio change lands one cycle later
    always_ff @(posedge divided_clk_src) begin
        if (!rst_n) begin
            divided_clks <= '0;
        end else begin
            divided_clks <= {prog_bits, fixed_bits};
        end
    end

endmodule

//--- verilog/io_clk_sel_buffer.sv
`timescale 1ns/1ps

module io_clk_sel_buffer (
    input  logic                    divided_clk_src,
    input  logic                    rst_n,
    input  logic                    clk_en,
    input  io_clk_pkg::div_taps_t   divided_clks,
    input  logic                    clock_update,
    input  io_clk_pkg::io_clk_sel_t clock_select,
    output logic                    target_clk
);

    import io_clk_pkg::*;

    io_clk_sel_t sel_latch;
    logic        retime_q;
    logic        sel_tap;

    // update lost if clk_en is low on the strobe
    always_ff @(posedge divided_clk_src) begin
        if (!rst_n) begin
            sel_latch <= '0;
        end else if (clock_update && clk_en) begin
            sel_latch <= clock_select;
        end
    end

    assign sel_tap = divided_clks[sel_latch];

    // re-timed copy for the programmable taps
    always_ff @(posedge divided_clk_src) begin
        if (!rst_n) begin
            retime_q <= 1'b0;
        end else if (clk_en) begin
            retime_q <= sel_tap;
        end
    end

    // taps 0..3 pass straight through
    always_comb begin
        casez (sel_latch)
            3'b001:  target_clk = divided_clks[1];
            3'b010:  target_clk = divided_clks[2];
            3'b011:  target_clk = divided_clks[3];
            3'b1??:  target_clk = retime_q;   // one enabled cycle late
            default: target_clk = divided_clks[0];
        endcase
    end

endmodule

//--- verilog/io_clk_gen.sv
`timescale 1ns/1ps

module io_clk_gen (
    input  logic                  divided_clk_src,
    input  logic                  rst_n,
    input  logic                  clk_en,
    input  logic                  cfg_wr,
    input  io_clk_pkg::cfg_addr_t cfg_addr,
    input  io_clk_pkg::cfg_data_t cfg_wdata,
    input  io_clk_pkg::cfg_addr_t cfg_rd_addr,
    output io_clk_pkg::cfg_data_t cfg_rdata,
    output logic                  target_clk
);

    import io_clk_pkg::*;

    io_clk_sel_t    clock_select;
    logic           clock_update;
    clk_ratio_vec_t divided_clk_sels;
    div_taps_t      divided_clks;

    io_clk_cfg_regs i_cfg_regs (
        .divided_clk_src  (divided_clk_src),
        .rst_n            (rst_n),
        .cfg_wr           (cfg_wr),
        .cfg_addr         (cfg_addr),
        .cfg_wdata        (cfg_wdata),
        .cfg_rd_addr      (cfg_rd_addr),
        .cfg_rdata        (cfg_rdata),
        .clock_select     (clock_select),
        .clock_update     (clock_update),
        .divided_clk_sels (divided_clk_sels)
    );

    io_clk_div_bank i_div_bank (
        .divided_clk_src  (divided_clk_src),
        .rst_n            (rst_n),
        .clk_en           (clk_en),
        .divided_clk_sels (divided_clk_sels),
        .divided_clks     (divided_clks)
    );

    io_clk_sel_buffer i_sel_buffer (
        .divided_clk_src  (divided_clk_src),
        .rst_n            (rst_n),
        .clk_en           (clk_en),
        .divided_clks     (divided_clks),
        .clock_update     (clock_update),
        .clock_select     (clock_select),
        .target_clk       (target_clk)
    );

endmodule

//--- test/io_clk_gen_sva.sv
`timescale 1ns/1ps

module io_clk_gen_sva (
    input logic                    divided_clk_src,
    input logic                    rst_n,
    input logic                    clk_en,
    input logic                    clock_update,
    input io_clk_pkg::io_clk_sel_t sel_latch,
    input logic                    retime_q,
    input logic                    target_clk
);

    import io_clk_pkg::*;

    // tap 0 and a low output once reset was seen
    property reset_clears_p;
        @(posedge divided_clk_src)
            !rst_n |=> (sel_latch == io_clk_sel_t'(0)) && !target_clk;
    endproperty

    // select only moves on an enabled update
    property sel_holds_p;
        @(posedge divided_clk_src)
            rst_n && !(clock_update && clk_en) |=> $stable(sel_latch);
    endproperty

    property retime_holds_p;
        @(posedge divided_clk_src)
            rst_n && !clk_en |=> $stable(retime_q);
    endproperty

    assert property (reset_clears_p)
        else $error("select latch or target_clk not cleared by reset");

    assert property (sel_holds_p)
        else $error("select latch changed without an enabled update");

    assert property (retime_holds_p)
        else $error("re-time register changed while clk_en was low");

endmodule

bind io_clk_sel_buffer io_clk_gen_sva i_sva (
    .divided_clk_src (divided_clk_src),
    .rst_n           (rst_n),
    .clk_en          (clk_en),
    .clock_update    (clock_update),
    .sel_latch       (sel_latch),
    .retime_q        (retime_q),
    .target_clk      (target_clk)
);

//--- test/io_clk_gen_tb.sv
`timescale 1ns/1ps
`include "io_clk_macros.svh"

module io_clk_gen_tb;

    import io_clk_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RUN_LEN      = 64;
    localparam int CYC_RESET    = 24;
    localparam int CYC_FIXED    = 4 * (RUN_LEN + 2);
    localparam int CYC_PROG     = 4 * (RUN_LEN + 3);
    localparam int CYC_ENABLE   = 2 * (RUN_LEN + 2) + 2 * (8 + 4);
    localparam int CYC_READBACK = 8 * 4;
    localparam int CYC_MARGIN   = 100;
    localparam int WD_CYCLES    = CYC_RESET + CYC_FIXED + CYC_PROG + CYC_ENABLE
                                  + CYC_READBACK + CYC_MARGIN;

    logic      divided_clk_src;
    logic      rst_n;
    logic      clk_en;
    logic      cfg_wr;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wdata;
    cfg_addr_t cfg_rd_addr;
    cfg_data_t cfg_rdata;
    logic      target_clk;

    // reference model state
    div_cnt_t       ref_cnt;
    div_taps_t      ref_taps;
    div_taps_t      ref_next_taps;
    io_clk_sel_t    ref_sel;
    clk_ratio_vec_t ref_ratio;
    logic           ref_upd;      // pending update strobe
    io_clk_sel_t    ref_lsel;     // latched select
    logic           ref_retime;   // tap level at the last enabled edge

    integer seed;
    string  test_name;
    bit     check_en;
    int     pass_cnt;
    int     fail_cnt;
    int     test_errs;

    io_clk_gen i_io_clk_gen (
        .divided_clk_src (divided_clk_src),
        .rst_n           (rst_n),
        .clk_en          (clk_en),
        .cfg_wr          (cfg_wr),
        .cfg_addr        (cfg_addr),
        .cfg_wdata       (cfg_wdata),
        .cfg_rd_addr     (cfg_rd_addr),
        .cfg_rdata       (cfg_rdata),
        .target_clk      (target_clk)
    );

    initial begin
        divided_clk_src = 1'b0;
        forever #(CLK_PERIOD / 2) divided_clk_src = ~divided_clk_src;
    end

    // tap levels for a counter value, tap t is counter bit r-1
    function automatic div_taps_t tap_levels(div_cnt_t cnt, clk_ratio_vec_t ratio);
        div_taps_t  taps;
        clk_ratio_t code;
        int         exp_r;
        for (int t = 0; t < `IO_CLK_NUM_FIXED; t++) begin
            taps[t] = cnt[t];   // fixed ratio 2**(t+1)
        end
        for (int i = 0; i < `IO_CLK_NUM_PROG; i++) begin
            code = ratio[2*i +: 2];
            exp_r = int'(code) + 1;
            taps[`IO_CLK_NUM_FIXED + i] = cnt[exp_r - 1];
        end
        return taps;
    endfunction

    function automatic logic expected_target(io_clk_sel_t lsel, div_taps_t taps,
                                             logic retimed);
        if (lsel >= io_clk_sel_t'(`IO_CLK_NUM_FIXED)) begin
            return retimed;   // one enabled cycle late
        end else begin
            return taps[lsel];
        end
    endfunction

    // model steps on every rising edge from old state
    always @(posedge divided_clk_src) begin
        if (!rst_n) begin
            ref_cnt    = '0;
            ref_taps   = '0;
            ref_sel    = '0;
            ref_ratio  = '0;
            ref_upd    = 1'b0;
            ref_lsel   = '0;
            ref_retime = 1'b0;
        end else begin
            ref_next_taps = tap_levels(ref_cnt, ref_ratio);
            if (clk_en) begin
                ref_retime = ref_taps[ref_lsel];
            end
            if (ref_upd && clk_en) begin
                ref_lsel = ref_sel;
            end
            ref_upd = cfg_wr && (cfg_addr == `IO_CLK_ADDR_SEL);
            if (cfg_wr && (cfg_addr == `IO_CLK_ADDR_SEL)) begin
                ref_sel = cfg_wdata[2:0];
            end
            if (cfg_wr && (cfg_addr == `IO_CLK_ADDR_RATIO)) begin
                ref_ratio = cfg_wdata;
            end
            if (clk_en) begin
                ref_cnt = ref_cnt + div_cnt_t'(1);
            end
            ref_taps = ref_next_taps;   // taps are registered
        end
    end

    task automatic check_clk(logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", test_name, exp, act);
            fail_cnt++;
            test_errs++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_data(cfg_data_t exp, cfg_data_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", test_name, exp, act);
            fail_cnt++;
            test_errs++;
        end else begin
            pass_cnt++;
        end
    endtask

    // target_clk is stable mid-cycle
    always @(negedge divided_clk_src) begin
        if (check_en) begin
            check_clk(expected_target(ref_lsel, ref_taps, ref_retime), target_clk);
        end
    end

    task automatic next_cycle();
        @(posedge divided_clk_src);
        #1;
    endtask

    task automatic run_cycles(int n, bit rand_en);
        logic [31:0] rnd;
        repeat (n) begin
            if (rand_en) begin
                rnd = $random(seed);
                clk_en = (rnd[1:0] != 2'b00);
            end else begin
                clk_en = 1'b1;
            end
            next_cycle();
        end
    endtask

    task automatic write_reg(cfg_addr_t addr, cfg_data_t data);
        cfg_wr = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    task automatic select_tap(io_clk_sel_t sel);
        clk_en = 1'b1;
        write_reg(`IO_CLK_ADDR_SEL, cfg_data_t'(sel));
        next_cycle();   // strobe meets clk_en high
    endtask

    // update strobe lands on a disabled edge
    task automatic write_sel_lost(io_clk_sel_t sel);
        clk_en = 1'b1;
        write_reg(`IO_CLK_ADDR_SEL, cfg_data_t'(sel));
        clk_en = 1'b0;
        next_cycle();
        clk_en = 1'b1;
    endtask

    task automatic read_check(cfg_addr_t addr, cfg_data_t exp);
        cfg_rd_addr = addr;
        @(negedge divided_clk_src);
        check_data(exp, cfg_rdata);
        next_cycle();
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s passed", test_name);
        end else begin
            $display("test %s failed with %0d mismatches", test_name, test_errs);
        end
    endtask

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("timeout: run still busy after %0d cycles", WD_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        cfg_data_t   wr_sel;
        cfg_data_t   wr_ratio;
        seed = 32'h875e;
        rst_n = 1'b0;
        clk_en = 1'b0;
        cfg_wr = 1'b0;
        cfg_addr = `IO_CLK_ADDR_SEL;
        cfg_wdata = '0;
        cfg_rd_addr = `IO_CLK_ADDR_SEL;
        check_en = 1'b0;
        pass_cnt = 0;
        fail_cnt = 0;

        start_test("reset");
        next_cycle();
        check_en = 1'b1;   // model reset by now
        clk_en = 1'b1;
        @(negedge divided_clk_src);
        check_clk(1'b0, target_clk);
        check_data(8'h00, cfg_rdata);
        next_cycle();
        rst_n = 1'b1;
        cfg_rd_addr = `IO_CLK_ADDR_RATIO;
        @(negedge divided_clk_src);
        check_data(8'h00, cfg_rdata);
        next_cycle();
        @(negedge divided_clk_src);
        check_clk(1'b0, target_clk);   // first cycle out of reset
        next_cycle();
        run_cycles(16, 1'b0);
        end_test();

        start_test("fixed_taps");
        for (int t = 0; t < `IO_CLK_NUM_FIXED; t++) begin
            select_tap(io_clk_sel_t'(t));
            run_cycles(RUN_LEN, 1'b0);
        end
        end_test();

        start_test("prog_taps");
        for (int t = `IO_CLK_NUM_FIXED; t < `IO_CLK_NUM_DIV; t++) begin
            rnd = $random(seed);
            write_reg(`IO_CLK_ADDR_RATIO, rnd[7:0]);
            select_tap(io_clk_sel_t'(t));
            run_cycles(RUN_LEN, 1'b0);
        end
        end_test();

        start_test("clk_enable");
        select_tap(3'd2);
        run_cycles(RUN_LEN, 1'b1);
        write_sel_lost(3'd6);   // stays on tap 2
        run_cycles(8, 1'b0);
        read_check(`IO_CLK_ADDR_SEL, 8'h06);
        select_tap(3'd5);
        run_cycles(RUN_LEN, 1'b1);
        write_sel_lost(3'd1);
        run_cycles(8, 1'b0);
        read_check(`IO_CLK_ADDR_SEL, 8'h01);
        end_test();

        start_test("readback");
        clk_en = 1'b1;
        repeat (8) begin
            rnd = $random(seed);
            wr_sel = rnd[7:0];
            wr_ratio = rnd[15:8];
            write_reg(`IO_CLK_ADDR_SEL, wr_sel);
            write_reg(`IO_CLK_ADDR_RATIO, wr_ratio);
            read_check(`IO_CLK_ADDR_SEL, {5'b0, wr_sel[2:0]});
            read_check(`IO_CLK_ADDR_RATIO, wr_ratio);
        end
        end_test();

        check_en = 1'b0;
        $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- io_clk_gen.f
+incdir+include
verilog/io_clk_pkg.sv
verilog/io_clk_cfg_regs.sv
verilog/io_clk_div_bank.sv
verilog/io_clk_sel_buffer.sv
verilog/io_clk_gen.sv
test/io_clk_gen_sva.sv
test/io_clk_gen_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the io_clk_gen testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f io_clk_gen.f \
    --top-module io_clk_gen_tb \
    -o io_clk_gen_sim

# a failing assertion can end the run early, the search below decides
out=$(./obj_dir/io_clk_gen_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx '\*\* PASS \*\*'; then
    exit 0
else
    exit 1
fi
